/* design/videoPkg.sv */
// Shared types and widths of the tile renderer; design modules import it where they need it
`default_nettype none

package videoPkg;

    // Frame sequencer states
    // stIdle waits for the run level, stDraw scans frames and stSwap flips the bank
    typedef enum logic [1:0]
    {
        stIdle = 2'd0,
        stDraw = 2'd1,
        stSwap = 2'd2
    } drawState_t;

    // Width of a palette index, which selects one of 16 palette slots
    localparam int cColorIdxW = 4;

    // Width of an output color, packed as red, green, blue with 4 bits each
    localparam int cRgbW = 12;

    // Width of a tile-map entry
    // Upper nibble is the foreground palette index, lower nibble the background index
    localparam int cTileEntryW = 8;

endpackage

`default_nettype wire

/* design/frameSequencer.sv */
// Frame sequencer that starts and stops scanning and swaps the display bank between frames
`timescale 1ns/1ps
`default_nettype none

module frameSequencer
    import videoPkg::*;
(
    input  wire  iCLK,
    input  wire  iRST,
    input  wire  iRun,
    input  wire  iSwapReq,
    input  wire  iFrameEnd,
    output logic oDrawEn,
    output logic oDispBank
);

    drawState_t state;
    drawState_t stateNext;
    logic       swapPending;
    logic       swapWanted;
    logic       frameStops;

    // A request in the frame-end cycle itself still counts for this boundary
    assign swapWanted = swapPending | iSwapReq;

    // The current frame is the last one of this drawing stretch
    assign frameStops = iFrameEnd & (swapWanted | ~iRun);

    // Enable drops already in the frame-end cycle, so the position counter
    // wraps to the origin and stops there without starting the next frame
    assign oDrawEn = (state == stDraw) & ~frameStops;

    always_comb
    begin
        stateNext = state;
        case (state)
            stIdle:
            begin
                if (iRun)
                    stateNext = stDraw;
            end
            stDraw:
            begin
                // Frames are atomic, so the state only moves at the frame boundary
                if (iFrameEnd & swapWanted)
                    stateNext = stSwap;
                else if (iFrameEnd & ~iRun)
                    stateNext = stIdle;
            end
            stSwap:
            begin
                stateNext = iRun ? stDraw : stIdle;
            end
            default:
            begin
                stateNext = stIdle;
            end
        endcase
    end

    always_ff @(posedge iCLK)
    begin
        if (iRST)
            state <= stIdle;
        else
            state <= stateNext;
    end

    // Swap requests are held until the next frame boundary consumes them
    // A request landing in the stSwap cycle waits for the following boundary
    always_ff @(posedge iCLK)
    begin
        if (iRST)
            swapPending <= 1'b0;
        else if (state == stSwap)
            swapPending <= iSwapReq;
        else if (iSwapReq)
            swapPending <= 1'b1;
    end

    // The display bank flips once per stSwap visit
    always_ff @(posedge iCLK)
    begin
        if (iRST)
            oDispBank <= 1'b0;
        else if (state == stSwap)
            oDispBank <= ~oDispBank;
    end

endmodule

`default_nettype wire

/* design/pixelDrawPosition.sv */
// Active-area position generator giving pixel and tile coordinates, a valid level and frame done
`timescale 1ns/1ps
`default_nettype none

module pixelDrawPosition #(
    parameter int pVHAW           = 11,
    parameter int pVVAW           = 11,
    parameter int pMapChipBasicBs = 4
)(
    input  wire                         iCLK,
    input  wire                         iRST,
    input  wire                         iCKE,
    input  wire  [pVHAW-1:0]            iVha,
    input  wire  [pVVAW-1:0]            iVva,
    output logic [pVHAW-1:0]            oHpos,
    output logic [pVVAW-1:0]            oVpos,
    output logic [pVHAW-1:pMapChipBasicBs] oHposBs,
    output logic [pVVAW-1:pMapChipBasicBs] oVposBs,
    output logic                        oFD,
    output logic                        oVD
);

    logic             hLast;
    logic             vLast;
    logic [pVHAW-1:0] hBeforeLast;
    logic             frameEndEarly;

    // Valid trails the clock enable by one cycle
    // The counters only move on cycles where the current position is valid
    always_ff @(posedge iCLK)
    begin
        if (iRST)
            oVD <= 1'b0;
        else
            oVD <= iCKE;
    end

    assign hLast = (oHpos == iVha);
    assign vLast = (oVpos == iVva);

    // Horizontal counter wraps after the last active column
    always_ff @(posedge iCLK)
    begin
        if (iRST)
            oHpos <= '0;
        else if (oVD)
            oHpos <= hLast ? '0 : oHpos + 1'b1;
    end

    // Vertical counter steps on each horizontal wrap and wraps after the last row
    always_ff @(posedge iCLK)
    begin
        if (iRST)
            oVpos <= '0;
        else if (oVD & hLast)
            oVpos <= vLast ? '0 : oVpos + 1'b1;
    end

    // Tile coordinates are the position with the fine bits dropped
    assign oHposBs = oHpos[pVHAW-1:pMapChipBasicBs];
    assign oVposBs = oVpos[pVVAW-1:pMapChipBasicBs];

    // Frame done is registered from the pixel just before the last one
    // Row pixels are consecutive within a frame, so the pulse lands on the last pixel
    assign hBeforeLast   = iVha - 1'b1;
    assign frameEndEarly = vLast & (oHpos == hBeforeLast);

    always_ff @(posedge iCLK)
    begin
        if (iRST)
            oFD <= 1'b0;
        else
            oFD <= oVD & frameEndEarly;
    end

endmodule

`default_nettype wire

/* design/tileMapRam.sv */
// Dual-bank tile-map memory with a host write port and a registered read by tile coordinate
`timescale 1ns/1ps
`default_nettype none

module tileMapRam
    import videoPkg::*;
#(
    parameter int pVHAW           = 11,
    parameter int pVVAW           = 11,
    parameter int pMapChipBasicBs = 4
)(
    input  wire                                        iCLK,
    input  wire                                        iWe,
    input  wire                                        iWrBank,
    input  wire  [pVVAW+pVHAW-2*pMapChipBasicBs-1:0]   iWrAddr,
    input  wire  [cTileEntryW-1:0]                     iWrData,
    input  wire                                        iDispBank,
    input  wire  [pVHAW-pMapChipBasicBs-1:0]           iHTile,
    input  wire  [pVVAW-pMapChipBasicBs-1:0]           iVTile,
    output logic [cTileEntryW-1:0]                     oEntry
);

    // Tile counts per axis follow from the coordinate widths and the tile edge
    localparam int cHTileW = pVHAW - pMapChipBasicBs;
    localparam int cVTileW = pVVAW - pMapChipBasicBs;
    localparam int cMapAw  = cHTileW + cVTileW;

    // Both banks sit in one array, the bank bit being the top address bit
    localparam int cDepth  = 2 << cMapAw;

    logic [cTileEntryW-1:0] mapMem [0:cDepth-1];
    logic [cMapAw:0]        wrIdx;
    logic [cMapAw:0]        rdIdx;

    // Host address is already vertical tile above horizontal tile
    assign wrIdx = {iWrBank, iWrAddr};

    // Read address uses the same layout, taken from the display bank
    assign rdIdx = {iDispBank, iVTile, iHTile};

    // Host writes may hit either bank at any time, including the shown one
    always_ff @(posedge iCLK)
    begin
        if (iWe)
            mapMem[wrIdx] <= iWrData;
    end

    // The registered read makes the entry follow its tile coordinate by one cycle
    always_ff @(posedge iCLK)
    begin
        oEntry <= mapMem[rdIdx];
    end

endmodule

`default_nettype wire

/* design/tilePaletteStage.sv */
// Palette stage applying the tile outline rule and looking up the 12-bit color
`timescale 1ns/1ps
`default_nettype none

module tilePaletteStage
    import videoPkg::*;
#(
    parameter int pMapChipBasicBs = 4
)(
    input  wire                        iCLK,
    input  wire                        iRST,
    input  wire  [cTileEntryW-1:0]     iEntry,
    input  wire  [pMapChipBasicBs-1:0] iFineH,
    input  wire  [pMapChipBasicBs-1:0] iFineV,
    input  wire                        iPalWe,
    input  wire  [cColorIdxW-1:0]      iPalAddr,
    input  wire  [cRgbW-1:0]           iPalData,
    output logic [cRgbW-1:0]           oRgb
);

    localparam int cPalDepth = 1 << cColorIdxW;

    logic [cRgbW-1:0]      palette [0:cPalDepth-1];
    logic                  onOutline;
    logic [cColorIdxW-1:0] fgIdx;
    logic [cColorIdxW-1:0] bgIdx;
    logic [cColorIdxW-1:0] colorIdx;

    // Split the entry into its two palette indexes
    assign fgIdx = iEntry[cTileEntryW-1 -: cColorIdxW];
    assign bgIdx = iEntry[cColorIdxW-1:0];

    // The first column and first row of every tile form its outline
    assign onOutline = (iFineH == '0) | (iFineV == '0);

    // Outline pixels take the foreground color, the tile interior the background
    assign colorIdx = onOutline ? fgIdx : bgIdx;

    // The host-writable palette shows a new color from the next cycle on
    always_ff @(posedge iCLK)
    begin
        if (iPalWe)
            palette[iPalAddr] <= iPalData;
    end

    // Color lookup is registered, adding one pipeline stage
    always_ff @(posedge iCLK)
    begin
        if (iRST)
            oRgb <= '0;
        else
            oRgb <= palette[colorIdx];
    end

endmodule

`default_nettype wire

/* design/tileRenderer.sv */
// Top level of the tile renderer, joining sequencer, position, map and palette with strobe delays
`timescale 1ns/1ps
`default_nettype none

module tileRenderer
    import videoPkg::*;
#(
    parameter int pVHAW           = 11,
    parameter int pVVAW           = 11,
    parameter int pMapChipBasicBs = 4
)(
    input  wire                                       iCLK,
    input  wire                                       iRST,
    input  wire                                       iRun,
    input  wire                                       iSwapReq,
    input  wire  [pVHAW-1:0]                          iVha,
    input  wire  [pVVAW-1:0]                          iVva,
    input  wire                                       iMapWe,
    input  wire                                       iMapBank,
    input  wire  [pVVAW+pVHAW-2*pMapChipBasicBs-1:0]  iMapAddr,
    input  wire  [cTileEntryW-1:0]                    iMapData,
    input  wire                                       iPalWe,
    input  wire  [cColorIdxW-1:0]                     iPalAddr,
    input  wire  [cRgbW-1:0]                          iPalData,
    output logic [cRgbW-1:0]                          oRgb,
    output logic                                      oPixelVd,
    output logic                                      oFrameDone,
    output logic                                      oDispBank
);

    logic                              drawEn;
    logic                              dispBank;
    logic                              posVd;
    logic [pVHAW-1:0]                  hPos;
    logic [pVVAW-1:0]                  vPos;
    logic [pVHAW-1:pMapChipBasicBs]    hTile;
    logic [pVVAW-1:pMapChipBasicBs]    vTile;
    logic                              frameEnd;
    logic [cTileEntryW-1:0]            tileEntry;

    // Stage one delay registers, lined up with the map read
    logic                              vdMap;
    logic                              feMap;
    logic [pMapChipBasicBs-1:0]        fineHMap;
    logic [pMapChipBasicBs-1:0]        fineVMap;

    // Stage two delay registers, lined up with the palette output
    logic                              vdPal;
    logic                              fePal;

    frameSequencer uSeq (
        .iCLK      (iCLK),
        .iRST      (iRST),
        .iRun      (iRun),
        .iSwapReq  (iSwapReq),
        .iFrameEnd (frameEnd),
        .oDrawEn   (drawEn),
        .oDispBank (dispBank)
    );

    pixelDrawPosition #(
        .pVHAW           (pVHAW),
        .pVVAW           (pVVAW),
        .pMapChipBasicBs (pMapChipBasicBs)
    ) uPos (
        .iCLK    (iCLK),
        .iRST    (iRST),
        .iCKE    (drawEn),
        .iVha    (iVha),
        .iVva    (iVva),
        .oHpos   (hPos),
        .oVpos   (vPos),
        .oHposBs (hTile),
        .oVposBs (vTile),
        .oFD     (frameEnd),
        .oVD     (posVd)
    );

    tileMapRam #(
        .pVHAW           (pVHAW),
        .pVVAW           (pVVAW),
        .pMapChipBasicBs (pMapChipBasicBs)
    ) uMap (
        .iCLK      (iCLK),
        .iWe       (iMapWe),
        .iWrBank   (iMapBank),
        .iWrAddr   (iMapAddr),
        .iWrData   (iMapData),
        .iDispBank (dispBank),
        .iHTile    (hTile),
        .iVTile    (vTile),
        .oEntry    (tileEntry)
    );

    tilePaletteStage #(
        .pMapChipBasicBs (pMapChipBasicBs)
    ) uPal (
        .iCLK     (iCLK),
        .iRST     (iRST),
        .iEntry   (tileEntry),
        .iFineH   (fineHMap),
        .iFineV   (fineVMap),
        .iPalWe   (iPalWe),
        .iPalAddr (iPalAddr),
        .iPalData (iPalData),
        .oRgb     (oRgb)
    );

    // Valid, frame done and the fine bits travel beside the pixel
    // Fine bits are only needed up to the palette stage
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            vdMap    <= 1'b0;
            feMap    <= 1'b0;
            fineHMap <= '0;
            fineVMap <= '0;
            vdPal    <= 1'b0;
            fePal    <= 1'b0;
        end
        else
        begin
            vdMap    <= posVd;
            feMap    <= frameEnd;
            fineHMap <= hPos[pMapChipBasicBs-1:0];
            fineVMap <= vPos[pMapChipBasicBs-1:0];
            vdPal    <= vdMap;
            fePal    <= feMap;
        end
    end

    assign oPixelVd   = vdPal;
    assign oFrameDone = fePal;
    assign oDispBank  = dispBank;

endmodule

`default_nettype wire

/* sim/tileRenderer_assertions.sv */
// Concurrent checks on the sequencer and output strobes, bound into the renderer top level
`timescale 1ns/1ps
`default_nettype none

module tileRenderer_assertions
    import videoPkg::*;
(
    input wire       iCLK,
    input wire       iRST,
    input wire       pixelVd,
    input wire       frameDone,
    input wire       dispBank,
    input wire       drawEn,
    input wire [1:0] seqState
);

    int failCount = 0;

    // Frame done rides on the last pixel, so it never shows up alone
    doneWithPixel: assert property (@(posedge iCLK) disable iff (iRST) frameDone |-> pixelVd)
    else
    begin
        failCount++;
        $error("frame done raised without a valid pixel");
    end

    // Every output pixel was started three cycles earlier by the draw enable in stDraw
    enableInDraw: assert property (@(posedge iCLK) disable iff (iRST)
        pixelVd |-> $past(drawEn && (seqState == stDraw), 3))
    else
    begin
        failCount++;
        $error("a valid pixel was not started by the draw enable in the draw state");
    end

    // The bank register flips right after the one-cycle swap state and never elsewhere
    bankFlipAfterSwap: assert property (@(posedge iCLK) disable iff (iRST)
        (dispBank != $past(dispBank)) |-> ($past(seqState) == stSwap))
    else
    begin
        failCount++;
        $error("display bank changed outside a swap");
    end

endmodule

bind tileRenderer tileRenderer_assertions uAsrt (
    .iCLK      (iCLK),
    .iRST      (iRST),
    .pixelVd   (oPixelVd),
    .frameDone (oFrameDone),
    .dispBank  (oDispBank),
    .drawEn    (drawEn),
    .seqState  (uSeq.state)
);

`default_nettype wire

/* sim/tileRendererTb.sv */
// Directed testbench for the tile renderer; draws frames and checks every pixel against a model
`timescale 1ns/1ps
`default_nettype none

module tileRendererTb;

    localparam int cHa       = 16;
    localparam int cVa       = 8;
    localparam int cTilesH   = 4;
    localparam int cFramePix = cHa * cVa;
    localparam int cPeriod   = 40;
    // Eight frames of drawing plus room for setup writes and idle gaps
    localparam int cWatchdogCycles = 8 * cFramePix + 1500;

    logic        iCLK = 1'b0;
    logic        iRST;
    logic        iRun;
    logic        iSwapReq;
    logic [5:0]  iVha;
    logic [4:0]  iVva;
    logic        iMapWe;
    logic        iMapBank;
    logic [6:0]  iMapAddr;
    logic [7:0]  iMapData;
    logic        iPalWe;
    logic [3:0]  iPalAddr;
    logic [11:0] iPalData;
    wire  [11:0] oRgb;
    wire         oPixelVd;
    wire         oFrameDone;
    wire         oDispBank;

    // Model copies of both map banks (eight tiles each) and of the palette
    logic [7:0]  mapModel [0:1][0:7];
    logic [11:0] palModel [0:15];
    logic [31:0] lfsr;
    logic [11:0] expRgb;
    logic        bankModel;
    logic        swapPending;
    int          pixCount;
    int          framesSeen;
    int          doneCount;
    int          errors;

    tileRenderer #(
        .pVHAW           (6),
        .pVVAW           (5),
        .pMapChipBasicBs (2)
    ) uut (.*);

    initial
    begin
        forever #(cPeriod / 2) iCLK = ~iCLK;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // Color of pixel (h, v) from the model bank and palette
    function automatic logic [11:0] expectedColor(input int h, input int v);
        logic [7:0] entry;
        logic [3:0] idx;
        entry = mapModel[bankModel][3'((v / 4) * cTilesH + h / 4)];
        // First column and first row of every tile take the foreground index
        if (h % 4 == 0 || v % 4 == 0)
            idx = entry[7:4];
        else
            idx = entry[3:0];
        return palModel[idx];
    endfunction

    task automatic valueError(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        errors++;
        $display("error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic plainError(input string msg);
        errors++;
        $display("%s (at %0t ns)", msg, $time);
    endtask

    task automatic writeTile(input logic bank, input int tile, input logic [7:0] data);
        @(negedge iCLK);
        iMapWe   = 1'b1;
        iMapBank = bank;
        // Vertical tile sits above the four horizontal tile bits
        iMapAddr = 7'((tile / cTilesH) * 16 + tile % cTilesH);
        iMapData = data;
        mapModel[bank][3'(tile)] = data;
        @(negedge iCLK);
        iMapWe = 1'b0;
    endtask

    task automatic fillBank(input logic bank);
        logic [7:0] data;
        for (int t = 0; t < 8; t++)
        begin
            data = 8'(takeBits(8));
            // Bank 1 must differ from bank 0 tile by tile so the swap is visible
            if (bank && data == mapModel[0][3'(t)])
                data = data ^ 8'h11;
            writeTile(bank, t, data);
        end
    endtask

    task automatic writePalette(input logic [3:0] idx, input logic [11:0] data);
        @(negedge iCLK);
        iPalWe   = 1'b1;
        iPalAddr = idx;
        iPalData = data;
        palModel[idx] = data;
        @(negedge iCLK);
        iPalWe = 1'b0;
    endtask

    task automatic fillPalette();
        logic [11:0] data;
        for (int i = 0; i < 16; i++)
        begin
            data = 12'(takeBits(12));
            // A rewritten slot always gets a new color
            if (data == palModel[4'(i)])
                data = data ^ 12'h001;
            writePalette(4'(i), data);
        end
    endtask

    // Wait until the monitor has reached the given pixel of the given frame
    task automatic waitPixel(input int frame, input int pix);
        do
            @(posedge iCLK);
        while (framesSeen < frame || (framesSeen == frame && pixCount < pix));
    endtask

    // Draws n frames, optionally pulsing a swap in the first one,
    // and drops run stopAt pixels into the last frame
    task automatic drawFrames(input int n, input int stopAt, input bit swap);
        int startFrame;
        int startDone;
        startFrame = framesSeen;
        startDone  = doneCount;
        @(negedge iCLK);
        iRun = 1'b1;
        if (swap)
        begin
            waitPixel(startFrame, 40);
            @(negedge iCLK);
            iSwapReq    = 1'b1;
            swapPending = 1'b1;
            @(negedge iCLK);
            iSwapReq = 1'b0;
        end
        waitPixel(startFrame + n - 1, stopAt);
        @(negedge iCLK);
        iRun = 1'b0;
        waitPixel(startFrame + n, 0);
        // Nothing may follow the last pixel of the stopped frame
        repeat (12)
        begin
            @(negedge iCLK);
            assert (!oPixelVd) else plainError("a valid pixel came after the run stopped");
        end
        assert (framesSeen - startFrame == n && doneCount - startDone == n)
        else
            plainError($sformatf("expected %0d frames, saw %0d frames and %0d done pulses",
                                 n, framesSeen - startFrame, doneCount - startDone));
    endtask

    task automatic checkIdleAfterReset();
        repeat (20)
        begin
            @(negedge iCLK);
            assert (!oPixelVd && !oFrameDone && !oDispBank)
            else
                plainError("an output strobe or the bank went high while idle after reset");
        end
    endtask

    task automatic drawBankZeroFrame();
        fillBank(1'b0);
        fillPalette();
        drawFrames(1, 64, 1'b0);
    endtask

    task automatic countDonePulses();
        drawFrames(3, 64, 1'b0);
    endtask

    task automatic swapBankMidFrame();
        fillBank(1'b1);
        drawFrames(2, 64, 1'b1);
        assert (oDispBank == 1'b1) else valueError("oDispBank", 32'd1, 32'(oDispBank));
    endtask

    task automatic stopRunMidFrame();
        drawFrames(1, 5, 1'b0);
    endtask

    task automatic rewritePalette();
        fillPalette();
        drawFrames(1, 64, 1'b0);
    endtask

    // The pixel monitor samples on the falling edge where the registered outputs have settled
    always @(negedge iCLK)
    begin
        if (!iRST)
        begin
            if (oPixelVd)
            begin
                if (pixCount == 0)
                    assert (oDispBank == bankModel)
                    else valueError("oDispBank", 32'(bankModel), 32'(oDispBank));
                expRgb = expectedColor(pixCount % cHa, pixCount / cHa);
                assert (oRgb == expRgb) else valueError("oRgb", 32'(expRgb), 32'(oRgb));
                assert (oFrameDone == (pixCount == cFramePix - 1))
                else
                    valueError("oFrameDone", 32'(pixCount == cFramePix - 1), 32'(oFrameDone));
                if (oFrameDone)
                    doneCount++;
                pixCount++;
                if (pixCount == cFramePix)
                begin
                    pixCount = 0;
                    framesSeen++;
                    // A swap requested during this frame shows from the next one on
                    if (swapPending)
                    begin
                        bankModel   = ~bankModel;
                        swapPending = 1'b0;
                    end
                end
            end
            else
                assert (!oFrameDone) else plainError("frame done came without a valid pixel");
        end
    end

    initial
    begin
        #(cWatchdogCycles * cPeriod);
        $display("timeout: the tests did not finish within %0d cycles", cWatchdogCycles);
        $display("tests failed");
        $finish;
    end

    initial
    begin
        iRST        = 1'b1;
        iRun        = 1'b0;
        iSwapReq    = 1'b0;
        iVha        = 6'd15;
        iVva        = 5'd7;
        iMapWe      = 1'b0;
        iMapBank    = 1'b0;
        iMapAddr    = '0;
        iMapData    = '0;
        iPalWe      = 1'b0;
        iPalAddr    = '0;
        iPalData    = '0;
        lfsr        = 32'h911b_7ec4;
        bankModel   = 1'b0;
        swapPending = 1'b0;
        pixCount    = 0;
        framesSeen  = 0;
        doneCount   = 0;
        errors      = 0;
        repeat (2) @(negedge iCLK);
        iRST = 1'b0;
        checkIdleAfterReset();
        drawBankZeroFrame();
        countDonePulses();
        swapBankMidFrame();
        stopRunMidFrame();
        rewritePalette();
        errors = errors + uut.uAsrt.failCount;
        $display("summary: %0d errors over %0d frames", errors, framesSeen);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
design/videoPkg.sv
design/frameSequencer.sv
design/pixelDrawPosition.sv
design/tileMapRam.sv
design/tilePaletteStage.sv
design/tileRenderer.sv
sim/tileRenderer_assertions.sv
sim/tileRendererTb.sv

/* Makefile */
TOP := tileRendererTb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only -Wall design/videoPkg.sv design/frameSequencer.sv \
	    design/pixelDrawPosition.sv design/tileMapRam.sv design/tilePaletteStage.sv \
	    design/tileRenderer.sv --top-module tileRenderer

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
